// ==== common/sram_queue_pkg.sv ====
/*
 * shared constants for the sram queue manager
 * queue, address, lane and memory word widths
 * field positions inside a memory word
 * burst state enum for write and read issue
 */

`default_nettype none

package sram_queue_pkg;

    ////////////////////////////////////////////////////////////
    // queues and address space
    ////////////////////////////////////////////////////////////

    localparam int num_queues   = 4;
    localparam int queue_id_w   = 2;
    localparam int addr_w       = 12;

    // offset bits below the queue select bits
    localparam int offset_w     = addr_w - queue_id_w;
    localparam int region_words = 1024;

    // queue reports full this many words before the region is used up
    localparam int full_margin  = 5;
    localparam int count_w      = addr_w - queue_id_w + 1;

    ////////////////////////////////////////////////////////////
    // memory word layout
    ////////////////////////////////////////////////////////////

    localparam int payload_w    = 96;
    localparam int lane_w       = 36;
    localparam int num_lanes    = 3;
    localparam int mem_word_w   = lane_w * num_lanes;

    // payload from the low bit up, then queue id, valid flag and zero pad
    localparam int qid_lsb      = payload_w;
    localparam int valid_bit    = payload_w + queue_id_w;
    localparam int pad_w        = mem_word_w - payload_w - queue_id_w - 1;

    ////////////////////////////////////////////////////////////
    // return lane buffering
    ////////////////////////////////////////////////////////////

    localparam int lane_fifo_depth = 4;
    localparam int fifo_ptr_w      = $clog2(lane_fifo_depth);

    // two-state issue rhythm, one idle cycle after each accept
    typedef enum logic {
        burst_off,
        burst_halfway
    } burst_state_t;

endpackage

`default_nettype wire

// ==== hdl/occupancy_tracker.sv ====
/*
 * per-queue occupancy counters
 * read_empty and write_full flags from the counts
 */

`timescale 1ns/100ps
`default_nettype none

module occupancy_tracker
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  write_accept,
    input  logic                                  read_accept,
    input  logic [sram_queue_pkg::queue_id_w-1:0] write_accept_queue,
    input  logic [sram_queue_pkg::queue_id_w-1:0] read_accept_queue,
    output logic [sram_queue_pkg::num_queues-1:0] read_empty,
    output logic [sram_queue_pkg::num_queues-1:0] write_full
);

    logic [sram_queue_pkg::count_w-1:0] count [sram_queue_pkg::num_queues];
    logic [sram_queue_pkg::num_queues-1:0] inc;
    logic [sram_queue_pkg::num_queues-1:0] dec;

    for (genvar q = 0; q < sram_queue_pkg::num_queues; q++)
    begin : g_queue
        assign inc[q] = write_accept && (write_accept_queue == q);
        assign dec[q] = read_accept && (read_accept_queue == q);

        // a write and a read on the same queue cancel out
        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                count[q] <= '0;
            end
            else if (inc[q] && !dec[q])
            begin
                count[q] <= count[q] + 1'b1;
            end
            else if (dec[q] && !inc[q])
            begin
                count[q] <= count[q] - 1'b1;
            end
        end

        // flags follow the registered count, one cycle after an accept
        assign read_empty[q] = (count[q] == '0);
        assign write_full[q] = (count[q] >= sram_queue_pkg::count_w'(
                                sram_queue_pkg::region_words - sram_queue_pkg::full_margin));

        // count stays inside 0 .. region_words
        assert property (@(posedge clk) disable iff (reset)
            (count[q] <= sram_queue_pkg::region_words)
            && !(dec[q] && !inc[q] && (count[q] == '0)));
    end

endmodule

`default_nettype wire

// ==== hdl/read_admit.sv ====
/*
 * read issue for the sram queue manager
 * per-queue read pointers, read burst state
 * registered memory read request
 */

`timescale 1ns/100ps
`default_nettype none

module read_admit
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  read_data_ready,
    input  logic [sram_queue_pkg::queue_id_w-1:0] read_queue_id,
    input  logic [sram_queue_pkg::num_queues-1:0] read_empty,
    output logic [sram_queue_pkg::addr_w-1:0]     din_addr,
    output logic                                  din_ready,
    output logic                                  read_accept,
    output logic [sram_queue_pkg::queue_id_w-1:0] read_accept_queue
);

    sram_queue_pkg::burst_state_t burst_state;
    logic [sram_queue_pkg::addr_w-1:0] read_ptr [sram_queue_pkg::num_queues];
    logic accept;

    // no request goes out for a queue with nothing stored
    assign accept = read_data_ready
                    && (burst_state == sram_queue_pkg::burst_off)
                    && !read_empty[read_queue_id];

    assign read_accept       = accept;
    assign read_accept_queue = read_queue_id;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            burst_state <= sram_queue_pkg::burst_off;
            din_ready   <= 1'b0;
            for (int q = 0; q < sram_queue_pkg::num_queues; q++)
            begin
                read_ptr[q] <= sram_queue_pkg::addr_w'(q * sram_queue_pkg::region_words);
            end
        end
        else
        begin
            din_ready <= accept;
            case (burst_state)
                sram_queue_pkg::burst_off:
                begin
                    if (accept)
                    begin
                        burst_state <= sram_queue_pkg::burst_halfway;
                    end
                end
                default:
                begin
                    burst_state <= sram_queue_pkg::burst_off;
                end
            endcase
            if (accept)
            begin
                read_ptr[read_queue_id][sram_queue_pkg::offset_w-1:0] <=
                    read_ptr[read_queue_id][sram_queue_pkg::offset_w-1:0] + 1'b1;
            end
        end
    end

    // address of the accepted read, presented with din_ready
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            din_addr <= read_ptr[read_queue_id];
        end
    end

    // request stays inside the region of the queue that asked for it
    assert property (@(posedge clk) disable iff (reset)
        din_ready |-> (din_addr[sram_queue_pkg::addr_w-1 -: sram_queue_pkg::queue_id_w]
                       == $past(read_queue_id)));

endmodule

`default_nettype wire

// ==== hdl/sram_queue_top.sv ====
/*
 * top level of the sram queue manager
 * issue stage with write admit, read admit and occupancy
 * return stage with lane realignment and unpack
 */

`timescale 1ns/100ps
`default_nettype none

module sram_queue_top
(
    input  logic                                  clk,
    input  logic                                  reset,

    // write side
    input  logic                                  write_data_valid,
    input  logic [sram_queue_pkg::queue_id_w-1:0] write_queue_id,
    input  logic [sram_queue_pkg::payload_w-1:0]  write_data,

    // read side
    input  logic                                  read_data_ready,
    input  logic [sram_queue_pkg::queue_id_w-1:0] read_queue_id,
    output logic [sram_queue_pkg::payload_w-1:0]  read_data,
    output logic [sram_queue_pkg::queue_id_w-1:0] read_data_queue_id,
    output logic                                  read_data_valid,

    // external memory
    output logic [sram_queue_pkg::mem_word_w-1:0] dout,
    output logic [sram_queue_pkg::addr_w-1:0]     dout_addr,
    output logic                                  dout_burst_ready,
    input  logic [sram_queue_pkg::mem_word_w-1:0] din,
    input  logic [sram_queue_pkg::num_lanes-1:0]  din_valid,
    output logic [sram_queue_pkg::addr_w-1:0]     din_addr,
    output logic                                  din_ready,

    // queue status
    output logic [sram_queue_pkg::num_queues-1:0] read_empty,
    output logic [sram_queue_pkg::num_queues-1:0] write_full
);

    logic                                  write_accept;
    logic [sram_queue_pkg::queue_id_w-1:0] write_accept_queue;
    logic                                  read_accept;
    logic [sram_queue_pkg::queue_id_w-1:0] read_accept_queue;

    ////////////////////////////////////////////////////////////
    // issue stage
    ////////////////////////////////////////////////////////////

    write_admit write_admit_i
    (
        .clk                (clk),
        .reset              (reset),
        .write_data_valid   (write_data_valid),
        .write_queue_id     (write_queue_id),
        .write_data         (write_data),
        .write_full         (write_full),
        .dout               (dout),
        .dout_addr          (dout_addr),
        .dout_burst_ready   (dout_burst_ready),
        .write_accept       (write_accept),
        .write_accept_queue (write_accept_queue)
    );

    read_admit read_admit_i
    (
        .clk               (clk),
        .reset             (reset),
        .read_data_ready   (read_data_ready),
        .read_queue_id     (read_queue_id),
        .read_empty        (read_empty),
        .din_addr          (din_addr),
        .din_ready         (din_ready),
        .read_accept       (read_accept),
        .read_accept_queue (read_accept_queue)
    );

    occupancy_tracker occupancy_tracker_i
    (
        .clk                (clk),
        .reset              (reset),
        .write_accept       (write_accept),
        .read_accept        (read_accept),
        .write_accept_queue (write_accept_queue),
        .read_accept_queue  (read_accept_queue),
        .read_empty         (read_empty),
        .write_full         (write_full)
    );

    ////////////////////////////////////////////////////////////
    // return stage
    ////////////////////////////////////////////////////////////

    return_merge return_merge_i
    (
        .clk                (clk),
        .reset              (reset),
        .din                (din),
        .din_valid          (din_valid),
        .read_data          (read_data),
        .read_data_queue_id (read_data_queue_id),
        .read_data_valid    (read_data_valid)
    );

endmodule

`default_nettype wire

// ==== hdl/write_admit.sv ====
/*
 * write issue for the sram queue manager
 * per-queue write pointers, write burst state
 * registered memory write request
 */

`timescale 1ns/100ps
`default_nettype none

module write_admit
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  write_data_valid,
    input  logic [sram_queue_pkg::queue_id_w-1:0] write_queue_id,
    input  logic [sram_queue_pkg::payload_w-1:0]  write_data,
    input  logic [sram_queue_pkg::num_queues-1:0] write_full,
    output logic [sram_queue_pkg::mem_word_w-1:0] dout,
    output logic [sram_queue_pkg::addr_w-1:0]     dout_addr,
    output logic                                  dout_burst_ready,
    output logic                                  write_accept,
    output logic [sram_queue_pkg::queue_id_w-1:0] write_accept_queue
);

    sram_queue_pkg::burst_state_t burst_state;
    logic [sram_queue_pkg::addr_w-1:0] write_ptr [sram_queue_pkg::num_queues];
    logic accept;

    // take the word only in the idle half of the burst and with room left
    assign accept = write_data_valid
                    && (burst_state == sram_queue_pkg::burst_off)
                    && !write_full[write_queue_id];

    assign write_accept       = accept;
    assign write_accept_queue = write_queue_id;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            burst_state      <= sram_queue_pkg::burst_off;
            dout_burst_ready <= 1'b0;
            for (int q = 0; q < sram_queue_pkg::num_queues; q++)
            begin
                write_ptr[q] <= sram_queue_pkg::addr_w'(q * sram_queue_pkg::region_words);
            end
        end
        else
        begin
            dout_burst_ready <= accept;
            case (burst_state)
                sram_queue_pkg::burst_off:
                begin
                    if (accept)
                    begin
                        burst_state <= sram_queue_pkg::burst_halfway;
                    end
                end
                default:
                begin
                    burst_state <= sram_queue_pkg::burst_off;
                end
            endcase
            // offset wraps on its own, queue select bits stay put
            if (accept)
            begin
                write_ptr[write_queue_id][sram_queue_pkg::offset_w-1:0] <=
                    write_ptr[write_queue_id][sram_queue_pkg::offset_w-1:0] + 1'b1;
            end
        end
    end

    // memory word and address, held until the next accept
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            dout      <= {{sram_queue_pkg::pad_w{1'b0}}, 1'b1, write_queue_id, write_data};
            dout_addr <= write_ptr[write_queue_id];
        end
    end

    // the burst rhythm leaves a gap after every memory write
    assert property (@(posedge clk) disable iff (reset)
        dout_burst_ready |=> !dout_burst_ready);

endmodule

`default_nettype wire

// ==== return_path/lane_skid_fifo.sv ====
/*
 * fall-through FIFO for one memory lane
 * head entry visible on rd_data while empty is low
 */

`timescale 1ns/100ps
`default_nettype none

module lane_skid_fifo
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wr_en,
    input  logic [sram_queue_pkg::lane_w-1:0] wr_data,
    input  logic                              rd_en,
    output logic [sram_queue_pkg::lane_w-1:0] rd_data,
    output logic                              empty
);

    logic [sram_queue_pkg::lane_w-1:0] mem [sram_queue_pkg::lane_fifo_depth];
    logic [sram_queue_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [sram_queue_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [sram_queue_pkg::fifo_ptr_w:0]   fill;
    logic full;

    assign empty   = (fill == '0);
    assign full    = (fill == sram_queue_pkg::lane_fifo_depth);
    assign rd_data = mem[rd_ptr];

    // pointers and fill level
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en)
            begin
                fill <= fill + 1'b1;
            end
            else if (rd_en && !wr_en)
            begin
                fill <= fill - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // memory returns cannot be stalled, so the lane must never overflow
    assert property (@(posedge clk) disable iff (reset)
        (wr_en && !rd_en) |-> !full);

endmodule

`default_nettype wire

// ==== return_path/return_merge.sv ====
/*
 * return stage of the sram queue manager
 * one FIFO per memory lane, joint pop when all hold data
 * unpacking of payload, queue id and valid flag
 */

`timescale 1ns/100ps
`default_nettype none

module return_merge
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [sram_queue_pkg::mem_word_w-1:0] din,
    input  logic [sram_queue_pkg::num_lanes-1:0]  din_valid,
    output logic [sram_queue_pkg::payload_w-1:0]  read_data,
    output logic [sram_queue_pkg::queue_id_w-1:0] read_data_queue_id,
    output logic                                  read_data_valid
);

    logic [sram_queue_pkg::mem_word_w-1:0] merged;
    logic [sram_queue_pkg::num_lanes-1:0]  lane_empty;
    logic pop;

    // lanes arrive skewed, each is buffered on its own strobe
    for (genvar k = 0; k < sram_queue_pkg::num_lanes; k++)
    begin : g_lane
        lane_skid_fifo lane_fifo_i
        (
            .clk     (clk),
            .reset   (reset),
            .wr_en   (din_valid[k]),
            .wr_data (din[k*sram_queue_pkg::lane_w +: sram_queue_pkg::lane_w]),
            .rd_en   (pop),
            .rd_data (merged[k*sram_queue_pkg::lane_w +: sram_queue_pkg::lane_w]),
            .empty   (lane_empty[k])
        );
    end

    // whole word present once no lane is empty
    assign pop = ~|lane_empty;

    assign read_data          = merged[sram_queue_pkg::payload_w-1:0];
    assign read_data_queue_id =
        merged[sram_queue_pkg::qid_lsb +: sram_queue_pkg::queue_id_w];
    assign read_data_valid    = pop && merged[sram_queue_pkg::valid_bit];

endmodule

`default_nettype wire

// ==== verification/sram_model.sv ====
/*
 * behavioral external SRAM for the queue manager testbench
 * fixed read latency, each lane returned with its own extra delay
 */

`timescale 1ns/100ps
`default_nettype none

module sram_model
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [sram_queue_pkg::mem_word_w-1:0] dout,
    input  logic [sram_queue_pkg::addr_w-1:0]     dout_addr,
    input  logic                                  dout_burst_ready,
    input  logic [sram_queue_pkg::addr_w-1:0]     din_addr,
    input  logic                                  din_ready,
    output logic [sram_queue_pkg::mem_word_w-1:0] din,
    output logic [sram_queue_pkg::num_lanes-1:0]  din_valid
);

    localparam int read_latency = 3;
    localparam int stages       = read_latency + sram_queue_pkg::num_lanes - 1;

    logic [sram_queue_pkg::mem_word_w-1:0] mem [1 << sram_queue_pkg::addr_w];
    logic [sram_queue_pkg::mem_word_w-1:0] pipe_word [stages];
    logic [stages-1:0] pipe_valid;

    always_ff @(posedge clk)
    begin
        if (dout_burst_ready)
        begin
            mem[dout_addr] <= dout;
        end
    end

    // read delay line, one stage per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pipe_valid <= '0;
        end
        else
        begin
            pipe_valid <= {pipe_valid[stages-2:0], din_ready};
        end
        pipe_word[0] <= mem[din_addr];
        for (int s = 1; s < stages; s++)
        begin
            pipe_word[s] <= pipe_word[s-1];
        end
    end

    // lane k taps the delay line k stages later than lane 0
    for (genvar k = 0; k < sram_queue_pkg::num_lanes; k++)
    begin : g_lane
        assign din_valid[k] = pipe_valid[read_latency-1+k];
        assign din[k*sram_queue_pkg::lane_w +: sram_queue_pkg::lane_w] =
            pipe_word[read_latency-1+k][k*sram_queue_pkg::lane_w +: sram_queue_pkg::lane_w];
    end

endmodule

`default_nettype wire

// ==== verification/sram_queue_tb.sv ====
/*
 * testbench for the sram queue manager
 * clock, reset, vector reader, issue checks
 * return scoreboard, burst rhythm monitor, timeout
 */

`timescale 1ns/100ps
`default_nettype none

module sram_queue_tb;

    localparam int pw         = sram_queue_pkg::payload_w;
    localparam int qw         = sram_queue_pkg::queue_id_w;
    localparam int nq         = sram_queue_pkg::num_queues;
    localparam int rw         = sram_queue_pkg::region_words;
    localparam int full_level = rw - sram_queue_pkg::full_margin;

    logic clk;
    logic reset;
    logic write_data_valid;
    logic [qw-1:0] write_queue_id;
    logic [pw-1:0] write_data;
    logic read_data_ready;
    logic [qw-1:0] read_queue_id;
    logic [pw-1:0] read_data;
    logic [qw-1:0] read_data_queue_id;
    logic read_data_valid;
    logic [sram_queue_pkg::mem_word_w-1:0] dout;
    logic [sram_queue_pkg::addr_w-1:0] dout_addr;
    logic dout_burst_ready;
    logic [sram_queue_pkg::mem_word_w-1:0] din;
    logic [sram_queue_pkg::num_lanes-1:0] din_valid;
    logic [sram_queue_pkg::addr_w-1:0] din_addr;
    logic din_ready;
    logic [nq-1:0] read_empty;
    logic [nq-1:0] write_full;

    // per-queue payload store, indexed by queue and write count
    logic [pw-1:0] stored [nq * rw];
    int wr_total [nq];
    int rd_total [nq];
    logic [pw-1:0] ret_payload [$];
    logic [qw-1:0] ret_queue [$];
    logic [7:0] op_code [$];
    logic [qw-1:0] op_queue [$];
    logic [pw-1:0] op_value [$];
    int seed;
    int errors;
    int cycle_count;
    int cycle_limit;
    logic last_dout_ready;
    logic last_din_ready;

    sram_queue_top sram_queue_top_i
    (
        .clk                (clk),
        .reset              (reset),
        .write_data_valid   (write_data_valid),
        .write_queue_id     (write_queue_id),
        .write_data         (write_data),
        .read_data_ready    (read_data_ready),
        .read_queue_id      (read_queue_id),
        .read_data          (read_data),
        .read_data_queue_id (read_data_queue_id),
        .read_data_valid    (read_data_valid),
        .dout               (dout),
        .dout_addr          (dout_addr),
        .dout_burst_ready   (dout_burst_ready),
        .din                (din),
        .din_valid          (din_valid),
        .din_addr           (din_addr),
        .din_ready          (din_ready),
        .read_empty         (read_empty),
        .write_full         (write_full)
    );

    sram_model sram_model_i
    (
        .clk              (clk),
        .reset            (reset),
        .dout             (dout),
        .dout_addr        (dout_addr),
        .dout_burst_ready (dout_burst_ready),
        .din_addr         (din_addr),
        .din_ready        (din_ready),
        .din              (din),
        .din_valid        (din_valid)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // failure reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        errors = errors + 1;
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_payload(input string name, input logic [pw-1:0] got,
                                 input logic [pw-1:0] exp);
        if (got !== exp)
        begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_queue_id(input string name, input logic [qw-1:0] got,
                                  input logic [qw-1:0] exp);
        if (got !== exp)
        begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name,
                              input logic [sram_queue_pkg::addr_w-1:0] got,
                              input logic [sram_queue_pkg::addr_w-1:0] exp);
        if (got !== exp)
        begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name,
                              input logic [sram_queue_pkg::mem_word_w-1:0] got,
                              input logic [sram_queue_pkg::mem_word_w-1:0] exp);
        if (got !== exp)
        begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_flags(input string name, input logic [nq-1:0] got,
                               input logic [nq-1:0] exp);
        if (got !== exp)
        begin
            report_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model of the queue state
    ////////////////////////////////////////////////////////////

    function automatic int queue_count(input int q);
        return wr_total[q] - rd_total[q];
    endfunction

    task automatic verify_status();
        logic [nq-1:0] exp_empty;
        logic [nq-1:0] exp_full;
        for (int q = 0; q < nq; q++)
        begin
            exp_empty[q] = (queue_count(q) == 0);
            exp_full[q]  = (queue_count(q) >= full_level);
        end
        check_flags("read_empty", read_empty, exp_empty);
        check_flags("write_full", write_full, exp_full);
    endtask

    ////////////////////////////////////////////////////////////
    // operations
    ////////////////////////////////////////////////////////////

    task automatic write_packet(input logic [qw-1:0] q, input logic [pw-1:0] payload);
        logic [sram_queue_pkg::mem_word_w-1:0] exp_word;
        logic [sram_queue_pkg::addr_w-1:0] exp_addr;
        @(posedge clk);
        #2;
        read_data_ready  = 1'b0;
        write_data_valid = 1'b1;
        write_queue_id   = q;
        write_data       = payload;
        if (queue_count(q) >= full_level)
        begin
            repeat (6)
            begin
                @(negedge clk);
                if (dout_burst_ready)
                begin
                    report_failure("write to a full queue was issued to memory");
                end
            end
        end
        else
        begin
            @(negedge clk);
            while (!dout_burst_ready)
            begin
                @(negedge clk);
            end
            // payload low, then queue id, then the valid flag
            exp_word = '0;
            exp_word[pw-1:0] = payload;
            exp_word[pw +: qw] = q;
            exp_word[pw + qw] = 1'b1;
            exp_addr = sram_queue_pkg::addr_w'(q * rw + wr_total[q] % rw);
            check_addr("dout_addr", dout_addr, exp_addr);
            check_word("dout", dout, exp_word);
            stored[q * rw + wr_total[q] % rw] = payload;
            wr_total[q] = wr_total[q] + 1;
        end
        verify_status();
    endtask

    task automatic read_packet(input logic [qw-1:0] q);
        logic [sram_queue_pkg::addr_w-1:0] exp_addr;
        @(posedge clk);
        #2;
        write_data_valid = 1'b0;
        read_data_ready  = 1'b1;
        read_queue_id    = q;
        if (queue_count(q) == 0)
        begin
            repeat (6)
            begin
                @(negedge clk);
                if (din_ready)
                begin
                    report_failure("read of an empty queue was issued to memory");
                end
            end
        end
        else
        begin
            @(negedge clk);
            while (!din_ready)
            begin
                @(negedge clk);
            end
            exp_addr = sram_queue_pkg::addr_w'(q * rw + rd_total[q] % rw);
            check_addr("din_addr", din_addr, exp_addr);
            ret_payload.push_back(stored[q * rw + rd_total[q] % rw]);
            ret_queue.push_back(q);
            rd_total[q] = rd_total[q] + 1;
        end
        verify_status();
    endtask

    task automatic idle_cycles(input int cycles);
        @(posedge clk);
        #2;
        write_data_valid = 1'b0;
        read_data_ready  = 1'b0;
        repeat (cycles)
        begin
            @(negedge clk);
        end
        verify_status();
    endtask

    // random payloads until the queue reaches its full level
    task automatic fill_queue(input logic [qw-1:0] q);
        logic [pw-1:0] payload;
        while (queue_count(q) < full_level)
        begin
            payload = {$random(seed), $random(seed), $random(seed)};
            write_packet(q, payload);
        end
    endtask

    task automatic load_vectors(output int n_fills);
        int fd;
        int code;
        string line;
        logic [7:0] op;
        logic [31:0] qv;
        logic [pw-1:0] val;
        n_fills = 0;
        fd = $fopen("verification/sram_queue_vectors.txt", "r");
        if (fd == 0)
        begin
            report_failure("cannot open verification/sram_queue_vectors.txt");
        end
        while (!$feof(fd))
        begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#")
            begin
                code = $sscanf(line, "%c %h %h", op, qv, val);
                if (code == 3)
                begin
                    op_code.push_back(op);
                    op_queue.push_back(qv[qw-1:0]);
                    op_value.push_back(val);
                    if (op == "f")
                    begin
                        n_fills = n_fills + 1;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // monitors
    ////////////////////////////////////////////////////////////

    // returned words leave the DUT in read issue order
    always @(negedge clk)
    begin : return_check
        logic [pw-1:0] exp_payload;
        logic [qw-1:0] exp_queue;
        if (!reset && read_data_valid)
        begin
            if (ret_payload.size() == 0)
            begin
                report_failure("read_data_valid with no read outstanding");
            end
            exp_payload = ret_payload.pop_front();
            exp_queue   = ret_queue.pop_front();
            check_payload("read_data", read_data, exp_payload);
            check_queue_id("read_data_queue_id", read_data_queue_id, exp_queue);
        end
    end

    always @(negedge clk)
    begin
        if (!reset && dout_burst_ready && last_dout_ready)
        begin
            report_failure("dout_burst_ready high in two consecutive cycles");
        end
        if (!reset && din_ready && last_din_ready)
        begin
            report_failure("din_ready high in two consecutive cycles");
        end
        last_dout_ready = reset ? 1'b0 : dout_burst_ready;
        last_din_ready  = reset ? 1'b0 : din_ready;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            report_failure($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin : main
        int n_fills;
        clk              = 1'b0;
        reset            = 1'b1;
        write_data_valid = 1'b0;
        write_queue_id   = '0;
        write_data       = '0;
        read_data_ready  = 1'b0;
        read_queue_id    = '0;
        seed             = 32'hd3224af0;
        errors           = 0;
        cycle_count      = 0;
        cycle_limit      = 1000;
        last_dout_ready  = 1'b0;
        last_din_ready   = 1'b0;
        for (int q = 0; q < nq; q++)
        begin
            wr_total[q] = 0;
            rd_total[q] = 0;
        end
        load_vectors(n_fills);
        // a fill is up to region_words writes of two cycles each, plus slack
        cycle_limit = 40 * op_code.size() + 3 * rw * n_fills + 200;

        repeat (2)
        begin
            @(posedge clk);
        end
        #2;
        reset = 1'b0;
        @(negedge clk);
        if (dout_burst_ready !== 1'b0 || din_ready !== 1'b0 || read_data_valid !== 1'b0)
        begin
            report_failure("memory strobes or read_data_valid not low after reset");
        end
        verify_status();

        for (int i = 0; i < op_code.size(); i++)
        begin
            case (op_code[i])
                "w": write_packet(op_queue[i], op_value[i]);
                "r": read_packet(op_queue[i]);
                "i": idle_cycles(int'(op_value[i]));
                "f": fill_queue(op_queue[i]);
                default: report_failure("unknown operation in vector file");
            endcase
        end

        // let every outstanding read come back
        idle_cycles(1);
        while (ret_payload.size() != 0)
        begin
            @(negedge clk);
        end
        repeat (8)
        begin
            @(negedge clk);
        end

        if (errors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/sram_queue_vectors.txt ====
# op queue value, all hex; w writes value to queue, r reads queue
# i idles value cycles, f fills queue with random payloads up to full
r 0 0
w 0 0123456789abcdef00112233
w 1 fedcba987654321044556677
r 0 0
w 2 a5a5a5a55a5a5a5a0f0f0f0f
r 1 0
w 0 deadbeefcafef00d12345678
w 3 000000010000000200000003
r 2 0
r 0 0
r 3 0
r 3 0
i 0 a
f 2 0
w 2 111111112222222233333333
w 1 444444445555555566666666
r 2 0
w 2 777777778888888899999999
r 1 0
r 1 0
i 0 14

// ==== verilog.f ====
common/sram_queue_pkg.sv
hdl/write_admit.sv
hdl/read_admit.sv
hdl/occupancy_tracker.sv
return_path/lane_skid_fifo.sv
return_path/return_merge.sv
hdl/sram_queue_top.sv
verification/sram_model.sv
verification/sram_queue_tb.sv
